// File: common/seq_io_pkg.sv
`default_nettype none

package seq_io_pkg;

	// Bit k is condition xk of the controller.
	typedef logic [20:1] cond_t;

	// Bit k is control line yk.
	typedef logic [38:1] ctrl_t;

	localparam ctrl_t ctrl_idle = '0;

	// Builds a control word from up to nine line numbers.
	// Unused arguments stay zero and set nothing.
	function automatic ctrl_t ctrl_of(
		input int unsigned n1 = 0,
		input int unsigned n2 = 0,
		input int unsigned n3 = 0,
		input int unsigned n4 = 0,
		input int unsigned n5 = 0,
		input int unsigned n6 = 0,
		input int unsigned n7 = 0,
		input int unsigned n8 = 0,
		input int unsigned n9 = 0
	);
		int unsigned nums [9];
		ctrl_t word;
		nums = '{n1, n2, n3, n4, n5, n6, n7, n8, n9};
		word = ctrl_idle;
		foreach (nums[k])
		begin
			if (nums[k] != 0)
			begin
				word[nums[k]] = 1'b1;
			end
		end
		return word;
	endfunction

endpackage

`default_nettype wire

// File: common/seq_state_pkg.sv
`default_nettype none

package seq_state_pkg;

	typedef enum logic [4:0] {
		st_idle,
		st_s2, st_s3, st_s4, st_s5, st_s6, st_s7, st_s8, st_s9, st_s10,
		st_s11, st_s12, st_s13, st_s14, st_s15, st_s16, st_s17, st_s18, st_s19, st_s20,
		st_s21, st_exit, st_s23, st_s24, st_s28, st_s33, st_s38
	} state_e;

	typedef struct packed {
		logic owned;                    // Decoder handles this state.
		state_e next;
		seq_io_pkg::ctrl_t ctrl;
	} step_t;

	localparam step_t step_none = '{owned: 1'b0, next: st_idle, ctrl: seq_io_pkg::ctrl_idle};

	function automatic step_t step_to(input state_e nxt, input seq_io_pkg::ctrl_t word);
		return '{owned: 1'b1, next: nxt, ctrl: word};
	endfunction

endpackage

`default_nettype wire

// File: entry/entry_decode.sv
`timescale 1ns/1ps
`default_nettype none

module entry_decode (
	input seq_state_pkg::state_e state,
	input seq_io_pkg::cond_t cond,
	output seq_state_pkg::step_t step
);

always_comb
begin
	case (state)
		seq_state_pkg::st_idle:
			if (cond[6] && cond[5] && cond[20])
				step = seq_state_pkg::step_to(seq_state_pkg::st_s2,
					seq_io_pkg::ctrl_of(2, 3, 4, 5, 8, 14, 29, 31, 35));
			else if (cond[6] && cond[5] && cond[19])
				step = seq_state_pkg::step_to(seq_state_pkg::st_s3,
					seq_io_pkg::ctrl_of(8, 14));
			else if (cond[6] && cond[5])
				step = seq_state_pkg::step_to(seq_state_pkg::st_s4,
					seq_io_pkg::ctrl_of(14, 32));
			else if (cond[6] && cond[4])
				step = seq_state_pkg::step_to(seq_state_pkg::st_s5,
					seq_io_pkg::ctrl_of(3, 4, 5, 6, 13, 18, 31, 32, 35));
			else if (cond[6])
				step = seq_state_pkg::step_to(seq_state_pkg::st_s6,
					seq_io_pkg::ctrl_of(3, 5, 7, 13));
			else
				step = seq_state_pkg::step_to(seq_state_pkg::st_idle,
					seq_io_pkg::ctrl_idle);     // No request yet.
		seq_state_pkg::st_s2:
			if (cond[19])
				step = seq_state_pkg::step_to(seq_state_pkg::st_s7,
					seq_io_pkg::ctrl_of(32, 34));
			else
				step = seq_state_pkg::step_to(seq_state_pkg::st_s8,
					seq_io_pkg::ctrl_of(32, 38));
		seq_state_pkg::st_s3:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s9,
				seq_io_pkg::ctrl_of(2, 3, 31, 32));
		seq_state_pkg::st_s4:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s10,
				seq_io_pkg::ctrl_of(3, 5, 13));
		seq_state_pkg::st_s5:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s11,
				seq_io_pkg::ctrl_of(13, 34));
		seq_state_pkg::st_s6:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s12,
				seq_io_pkg::ctrl_of(19));
		seq_state_pkg::st_s7:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s13,
				seq_io_pkg::ctrl_of(30));
		seq_state_pkg::st_s8:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s14,
				seq_io_pkg::ctrl_of(30));
		seq_state_pkg::st_s9:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s15,
				seq_io_pkg::ctrl_of(30));
		seq_state_pkg::st_s10:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s16,
				seq_io_pkg::ctrl_of(30));
		seq_state_pkg::st_s11:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s17,
				seq_io_pkg::ctrl_of(30));
		seq_state_pkg::st_s12:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s18,
				seq_io_pkg::ctrl_of(4, 7, 13, 35));
		seq_state_pkg::st_s13:
			step = seq_state_pkg::step_to(seq_state_pkg::st_idle,
				seq_io_pkg::ctrl_of(13, 31, 34));
		seq_state_pkg::st_s14:
			step = seq_state_pkg::step_to(seq_state_pkg::st_idle,
				seq_io_pkg::ctrl_of(13, 31, 38));
		seq_state_pkg::st_s15:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s19,
				seq_io_pkg::ctrl_of(4, 13, 29));
		seq_state_pkg::st_s16:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s19,
				seq_io_pkg::ctrl_of(4, 13, 35));
		seq_state_pkg::st_s17:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s20,
				seq_io_pkg::ctrl_of(13, 31, 34));
		seq_state_pkg::st_s18:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s21,
				seq_io_pkg::ctrl_of(19, 37));   // Hand over to dispatch.
		seq_state_pkg::st_s19:
			step = seq_state_pkg::step_to(seq_state_pkg::st_idle,
				seq_io_pkg::ctrl_idle);
		seq_state_pkg::st_s20:
			step = seq_state_pkg::step_to(seq_state_pkg::st_idle,
				seq_io_pkg::ctrl_of(14, 17, 18, 20, 36));
		default:
			step = seq_state_pkg::step_none;
	endcase
end

endmodule

`default_nettype wire

// File: dispatch/dispatch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_decode (
	input seq_state_pkg::state_e state,
	input seq_io_pkg::cond_t cond,
	output seq_state_pkg::step_t step
);

logic exit_hit;
logic chain_take;
logic direct_take;
seq_io_pkg::ctrl_t exit_word;

// Exit rule of s22, also applied inline by several s21 rows.
assign exit_hit = cond[18] && (cond[10] || cond[11]);
assign exit_word = exit_hit ? seq_io_pkg::ctrl_of(33) : seq_io_pkg::ctrl_idle;

assign chain_take = cond[16] ? cond[11] : cond[10];
assign direct_take = cond[15] ? (cond[16] || cond[9]) : (cond[16] ? cond[8] : cond[7]);

always_comb
begin
	case (state)
		seq_state_pkg::st_s21:
		begin
			// Rows into the removed branch fall through to this.
			step = seq_state_pkg::step_to(seq_state_pkg::st_exit, seq_io_pkg::ctrl_idle);
			if (cond[12] && cond[14])
			begin
				if (!cond[13])
				begin
					step.ctrl = seq_io_pkg::ctrl_of(9, 10, 11, 12);
					step.next = seq_state_pkg::st_s23;
				end
				else if (cond[16])
					step.ctrl = seq_io_pkg::ctrl_of(20);
				else
					step.ctrl = seq_io_pkg::ctrl_of(24);
			end
			else if (cond[12] && cond[13] && cond[15])
			begin
				step.ctrl = cond[16] ? seq_io_pkg::ctrl_of(22, 23)
					: seq_io_pkg::ctrl_of(7, 14, 15, 21);
			end
			else if (cond[12] && cond[13])
			begin
				if (chain_take)
				begin
					step.ctrl = seq_io_pkg::ctrl_of(19);
					step.next = seq_state_pkg::st_s24;
				end
				else
				begin
					step.ctrl = exit_word;         // Early exit.
					step.next = seq_state_pkg::st_idle;
				end
			end
			else if (cond[12] && cond[15])
			begin
				step.ctrl = seq_io_pkg::ctrl_of(9, 10, 11, 12);
				step.next = seq_state_pkg::st_s23;
			end
			else if (cond[12] && !cond[3] && !cond[2])
			begin
				step.ctrl = cond[16] ? seq_io_pkg::ctrl_of(7, 15, 16)
					: seq_io_pkg::ctrl_of(1, 7, 15);
			end
			else if (!cond[12] && !cond[3] && cond[13])
			begin
				if (direct_take)
					step.ctrl = seq_io_pkg::ctrl_of(1, 7, 17);
				else
				begin
					step.ctrl = exit_word;
					step.next = seq_state_pkg::st_idle;
				end
			end
		end
		seq_state_pkg::st_exit:
			step = seq_state_pkg::step_to(seq_state_pkg::st_idle, exit_word);
		seq_state_pkg::st_s23:
			step = seq_state_pkg::step_to(seq_state_pkg::st_exit,
				seq_io_pkg::ctrl_of(13, 14, 15));
		seq_state_pkg::st_s24:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s28,
				seq_io_pkg::ctrl_of(19));
		seq_state_pkg::st_s28:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s33,
				seq_io_pkg::ctrl_of(19));
		seq_state_pkg::st_s33:
			step = seq_state_pkg::step_to(seq_state_pkg::st_s38,
				seq_io_pkg::ctrl_of(19));
		seq_state_pkg::st_s38:
			step = seq_state_pkg::step_to(seq_state_pkg::st_exit,
				seq_io_pkg::ctrl_of(20));
		default:
			step = seq_state_pkg::step_none;
	endcase
end

endmodule

`default_nettype wire

// File: logic/state_core.sv
`timescale 1ns/1ps
`default_nettype none

module state_core (
	input logic rst,
	input logic clk,
	input seq_state_pkg::step_t entry_step,
	input seq_state_pkg::step_t dispatch_step,
	output seq_state_pkg::state_e state,
	output seq_io_pkg::ctrl_t ctrl
);

seq_state_pkg::state_e next_state;

always_comb
begin
	if (entry_step.owned)
	begin
		next_state = entry_step.next;
		ctrl = entry_step.ctrl;
	end
	else if (dispatch_step.owned)
	begin
		next_state = dispatch_step.next;
		ctrl = dispatch_step.ctrl;
	end
	else
	begin
		next_state = seq_state_pkg::st_idle;   // Unused encoding.
		ctrl = seq_io_pkg::ctrl_idle;
	end
end

always_ff @(posedge rst or negedge clk)
begin
	if (!clk)
		state <= seq_state_pkg::st_idle;
	else
		state <= next_state;
end

endmodule

`default_nettype wire

// File: logic/seq_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl_top (
	input logic rst,
	input logic clk,
	input seq_io_pkg::cond_t cond,
	output seq_io_pkg::ctrl_t ctrl
);

seq_state_pkg::state_e state;
seq_state_pkg::step_t entry_step;
seq_state_pkg::step_t dispatch_step;

entry_decode i_entry (
	.state (state),
	.cond  (cond),
	.step  (entry_step)
);

dispatch_decode i_dispatch (
	.state (state),
	.cond  (cond),
	.step  (dispatch_step)
);

state_core i_core (
	.rst           (rst),
	.clk           (clk),
	.entry_step    (entry_step),
	.dispatch_step (dispatch_step),
	.state         (state),
	.ctrl          (ctrl)
);

endmodule

`default_nettype wire

// File: dv/seq_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl_tb;

logic rst;
logic clk;
seq_io_pkg::cond_t cond;
seq_io_pkg::ctrl_t ctrl;

integer seed;
int mismatch_count;
seq_io_pkg::cond_t idle_mask;

seq_ctrl_top i_dut (
	.rst  (rst),
	.clk  (clk),
	.cond (cond),
	.ctrl (ctrl)
);

initial
begin
	rst = 1'b0;
	forever
	begin
		#20 rst = ~rst;
	end
end

function automatic seq_io_pkg::ctrl_t line_bit(input int n);
	seq_io_pkg::ctrl_t w;
	w = '0;
	w[n] = 1'b1;
	return w;
endfunction

function automatic seq_io_pkg::cond_t cond_bit(input int n);
	seq_io_pkg::cond_t w;
	w = '0;
	w[n] = 1'b1;
	return w;
endfunction

// Tested bits forced, every other bit random.
function automatic seq_io_pkg::cond_t random_cond(input seq_io_pkg::cond_t mask,
	input seq_io_pkg::cond_t val);
	seq_io_pkg::cond_t r;
	r = seq_io_pkg::cond_t'($random(seed));
	return (r & ~mask) | (val & mask);
endfunction

function automatic seq_io_pkg::ctrl_t exit_expect(input seq_io_pkg::cond_t c);
	if (c[18] && (c[10] || c[11]))
		return line_bit(33);
	return '0;
endfunction

task automatic step_check(input string name, input seq_io_pkg::cond_t c,
	input seq_io_pkg::ctrl_t exp);
	@(posedge rst);
	cond <= c;
	#10;                                     // Mealy word settled.
	assert (ctrl === exp)
	else
	begin
		$display("Mismatch %s expected %h actual %h", name, exp, ctrl);
		mismatch_count++;
	end
endtask

// Idle to s6, s12, s18 and into s21.
task automatic run_to_dispatch(input string name);
	step_check(name, random_cond(idle_mask, cond_bit(6)),
		line_bit(3) | line_bit(5) | line_bit(7) | line_bit(13));
	step_check(name, random_cond('0, '0), line_bit(19));
	step_check(name, random_cond('0, '0),
		line_bit(4) | line_bit(7) | line_bit(13) | line_bit(35));
	step_check(name, random_cond('0, '0), line_bit(19) | line_bit(37));
endtask

initial
begin
	seq_io_pkg::ctrl_t s2_word;
	seq_io_pkg::cond_t m;
	seq_io_pkg::cond_t c;
	seed = 40304;
	mismatch_count = 0;
	clk = 1'b0;
	cond = '0;
	idle_mask = cond_bit(6) | cond_bit(5) | cond_bit(4) | cond_bit(20) | cond_bit(19);
	s2_word = line_bit(2) | line_bit(3) | line_bit(4) | line_bit(5) | line_bit(8)
		| line_bit(14) | line_bit(29) | line_bit(31) | line_bit(35);
	repeat (16) step_check("reset", '0, '0);
	@(posedge rst);
	clk <= 1'b1;

	repeat (20) step_check("idle", '0, '0);
	repeat (8) step_check("idle_no_x6", random_cond(cond_bit(6), '0), '0);

	m = cond_bit(6) | cond_bit(5) | cond_bit(20);
	step_check("entry_s2_x19", random_cond(idle_mask, m), s2_word);
	step_check("entry_s2_x19", random_cond(cond_bit(19), cond_bit(19)),
		line_bit(32) | line_bit(34));
	step_check("entry_s2_x19", random_cond('0, '0), line_bit(30));
	step_check("entry_s2_x19", random_cond('0, '0),
		line_bit(13) | line_bit(31) | line_bit(34));
	step_check("entry_s2_x19", '0, '0);
	step_check("entry_s2_no_x19", random_cond(idle_mask, m), s2_word);
	step_check("entry_s2_no_x19", random_cond(cond_bit(19), '0),
		line_bit(32) | line_bit(38));
	step_check("entry_s2_no_x19", random_cond('0, '0), line_bit(30));
	step_check("entry_s2_no_x19", random_cond('0, '0),
		line_bit(13) | line_bit(31) | line_bit(38));
	step_check("entry_s2_no_x19", '0, '0);

	step_check("entry_s5", random_cond(idle_mask, cond_bit(6) | cond_bit(4)),
		line_bit(3) | line_bit(4) | line_bit(5) | line_bit(6) | line_bit(13)
		| line_bit(18) | line_bit(31) | line_bit(32) | line_bit(35));
	step_check("entry_s5", random_cond('0, '0), line_bit(13) | line_bit(34));
	step_check("entry_s5", random_cond('0, '0), line_bit(30));
	step_check("entry_s5", random_cond('0, '0),
		line_bit(13) | line_bit(31) | line_bit(34));
	step_check("entry_s5", random_cond('0, '0), line_bit(14) | line_bit(17)
		| line_bit(18) | line_bit(20) | line_bit(36));
	step_check("entry_s5", '0, '0);

	run_to_dispatch("dispatch_exit");
	m = cond_bit(12) | cond_bit(13) | cond_bit(14) | cond_bit(16);
	step_check("dispatch_exit", random_cond(m, m), line_bit(20));
	m = cond_bit(18) | cond_bit(10);
	step_check("dispatch_exit", random_cond(m, m), line_bit(33));
	run_to_dispatch("dispatch_s23");
	m = cond_bit(12) | cond_bit(13) | cond_bit(14);
	step_check("dispatch_s23", random_cond(m, cond_bit(12) | cond_bit(14)),
		line_bit(9) | line_bit(10) | line_bit(11) | line_bit(12));
	step_check("dispatch_s23", random_cond('0, '0),
		line_bit(13) | line_bit(14) | line_bit(15));
	step_check("dispatch_s23", random_cond(cond_bit(18), '0), '0);

	// Exit word varies with the random x10, x11 and x18.
	repeat (4)
	begin
		run_to_dispatch("dispatch_chain");
		m = cond_bit(11) | cond_bit(12) | cond_bit(13) | cond_bit(14)
			| cond_bit(15) | cond_bit(16);
		c = random_cond(m, cond_bit(11) | cond_bit(12) | cond_bit(13) | cond_bit(16));
		step_check("dispatch_chain", c, line_bit(19));
		repeat (3) step_check("dispatch_chain", random_cond('0, '0), line_bit(19));
		step_check("dispatch_chain", random_cond('0, '0), line_bit(20));
		c = random_cond('0, '0);
		step_check("dispatch_chain", c, exit_expect(c));
	end

	run_to_dispatch("dropped_branch");
	m = cond_bit(3) | cond_bit(12);
	step_check("dropped_branch", random_cond(m, cond_bit(3)), '0);
	m = cond_bit(18) | cond_bit(11);
	step_check("dropped_branch", random_cond(m, m), line_bit(33));
	step_check("dropped_branch", '0, '0);

	$display("Mismatches: %0d", mismatch_count);
	if (mismatch_count == 0)
		$display("All checks passed");
	else
		$display("Checks failed");
	$finish;
end

endmodule

`default_nettype wire

// File: seq_ctrl.f
common/seq_io_pkg.sv
common/seq_state_pkg.sv
entry/entry_decode.sv
dispatch/dispatch_decode.sv
logic/state_core.sv
logic/seq_ctrl_top.sv
dv/seq_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module seq_ctrl_tb -f seq_ctrl.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vseq_ctrl_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
